/* ptp_pkg.sv */
//**************************************************************************
// precision time package: 96-bit timestamp type, field widths, the
// nanosecond rollover constant, configuration address codes and defaults
//**************************************************************************
package ptp_pkg;

    // timestamp field widths
    localparam int SEC_W = 48;
    localparam int NS_W  = 32;
    localparam int FNS_W = 16;

    // nanoseconds with one bit of headroom, joined with fns for the adders
    localparam int NS_SUM_W = 31;
    localparam int NSF_W    = NS_SUM_W + FNS_W;

    // seconds in [95:48], nanoseconds in [47:16] (top 2 bits zero), fns in [15:0]
    typedef struct packed {
        logic [SEC_W-1:0] sec;
        logic [NS_W-1:0]  ns;
        logic [FNS_W-1:0] fns;
    } ptp_ts_t;

    localparam logic [NS_SUM_W-1:0] NS_PER_SEC = 31'd1_000_000_000;

    // one second on the joined ns:fns scale
    localparam logic [NSF_W-1:0] NSF_ONE_SEC = {NS_PER_SEC, {FNS_W{1'b0}}};

    // configuration write addresses, bit 0 of the control word is enable
    localparam logic [1:0] CFG_ADDR_START  = 2'd0;
    localparam logic [1:0] CFG_ADDR_PERIOD = 2'd1;
    localparam logic [1:0] CFG_ADDR_WIDTH  = 2'd2;
    localparam logic [1:0] CFG_ADDR_CTRL   = 2'd3;

    // power-up settings: start at zero, one pulse per second, 1 us high
    localparam ptp_ts_t PTP_DEF_START  = '{sec: 48'd0, ns: 32'd0, fns: 16'd0};
    localparam ptp_ts_t PTP_DEF_PERIOD = '{sec: 48'd1, ns: 32'd0, fns: 16'd0};
    localparam ptp_ts_t PTP_DEF_WIDTH  = '{sec: 48'd0, ns: 32'd1000, fns: 16'd0};

endpackage

/* ptp_cfg_if.sv */
//**************************************************************************
// decoded periodic output settings, from the config decoder to the
// edge scheduler and the pulse result block
//**************************************************************************
`timescale 1ns/100ps

interface ptp_cfg_if
    import ptp_pkg::*;
();

    ptp_ts_t start;
    ptp_ts_t period;
    ptp_ts_t width;
    logic    enable;
    // one cycle pulse after a start or period write
    logic    reload;

    modport drv (output start, period, width, enable, reload);

    modport sched (input start, period, width, reload);

    modport status (input enable);

endinterface

/* ptp_edge_if.sv */
//**************************************************************************
// edge events from the scheduler to the pulse result block
//**************************************************************************
`timescale 1ns/100ps

interface ptp_edge_if ();

    // all single cycle pulses, absorbed by the receiver on arrival
    logic rise_evt;
    logic fall_evt;
    logic resync;
    // qualifies resync when the restart came from a time load
    logic step_evt;

    modport drv (output rise_evt, fall_evt, resync, step_evt);

    modport rcv (input rise_evt, fall_evt, resync, step_evt);

endinterface

/* ptp_tod_clock.sv */
//**************************************************************************
// PTP time-of-day counter: adds a fixed ns/fns increment every cycle,
// rolls nanoseconds into seconds at one billion, and can be stepped
//**************************************************************************
`timescale 1ns/100ps

module ptp_tod_clock
    import ptp_pkg::*;
#(
    parameter int unsigned NS_INC  = 4,
    parameter int unsigned FNS_INC = 0
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    ts_set,
    input  ptp_ts_t ts_set_value,
    output ptp_ts_t ts_96,
    output logic    ts_step
);

    localparam logic [NSF_W-1:0] INC = {NS_SUM_W'(NS_INC), FNS_W'(FNS_INC)};

    logic [NSF_W-1:0] nsf_cur;
    logic [NSF_W-1:0] nsf_sum;
    logic [NSF_W-1:0] nsf_ovf;

    assign nsf_cur = {ts_96.ns[NS_SUM_W-1:0], ts_96.fns};
    assign nsf_sum = nsf_cur + INC;
    // top bit set means the sum stayed below one second
    assign nsf_ovf = nsf_sum - NSF_ONE_SEC;

    always_ff @(posedge clk) begin
        if (rst) begin
            ts_96   <= '0;
            ts_step <= 1'b0;
        end else begin
            ts_step <= ts_set;
            if (ts_set) begin
                ts_96 <= ts_set_value;
            end else if (!nsf_ovf[NSF_W-1]) begin
                ts_96.sec <= ts_96.sec + 1'b1;
                {ts_96.ns, ts_96.fns} <= {1'b0, nsf_ovf};
            end else begin
                {ts_96.ns, ts_96.fns} <= {1'b0, nsf_sum};
            end
        end
    end

    // a valid load keeps the count inside one second from then on
    a_ns_range: assert property (
        @(posedge clk) disable iff (rst)
        ts_96.ns < NS_PER_SEC
    );

endmodule

/* ptp_cfg_decode.sv */
//**************************************************************************
// configuration decode: write strobes into held start, period, width
// and enable settings, with a reload pulse on start or period change
//**************************************************************************
`timescale 1ns/100ps

module ptp_cfg_decode
    import ptp_pkg::*;
#(
    parameter ptp_ts_t DEF_START  = PTP_DEF_START,
    parameter ptp_ts_t DEF_PERIOD = PTP_DEF_PERIOD,
    parameter ptp_ts_t DEF_WIDTH  = PTP_DEF_WIDTH
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cfg_wr,
    input  logic [1:0] cfg_addr,
    input  ptp_ts_t    cfg_data,
    ptp_cfg_if.drv     cfg
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.start  <= DEF_START;
            cfg.period <= DEF_PERIOD;
            cfg.width  <= DEF_WIDTH;
            cfg.enable <= 1'b0;
            cfg.reload <= 1'b0;
        end else begin
            // width changes take effect on the next fall update, no restart
            cfg.reload <= cfg_wr &&
                          (cfg_addr == CFG_ADDR_START || cfg_addr == CFG_ADDR_PERIOD);
            if (cfg_wr) begin
                case (cfg_addr)
                    CFG_ADDR_START:  cfg.start  <= cfg_data;
                    CFG_ADDR_PERIOD: cfg.period <= cfg_data;
                    CFG_ADDR_WIDTH:  cfg.width  <= cfg_data;
                    CFG_ADDR_CTRL:   cfg.enable <= cfg_data[0];
                endcase
            end
        end
    end

    // back to back reloads need back to back writes
    a_reload_src: assert property (
        @(posedge clk) disable iff (rst)
        (cfg.reload && $past(cfg.reload)) |-> ($past(cfg_wr) && $past(cfg_wr, 2))
    );

endmodule

/* ptp_edge_sched.sv */
//**************************************************************************
// periodic output edge scheduler: tracks next rise and fall times,
// compares against registered time, fast-forwards past start times
//**************************************************************************
`timescale 1ns/100ps

module ptp_edge_sched
    import ptp_pkg::*;
#(
    parameter bit FNS_ENABLE = 1'b1
) (
    input  logic    clk,
    input  logic    rst,
    input  ptp_ts_t ts_96,
    input  logic    ts_step,
    ptp_cfg_if.sched cfg,
    ptp_edge_if.drv edge_bus
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RISE_1,
        S_RISE_2,
        S_FALL_1,
        S_FALL_2,
        S_WAIT_EDGE
    } state_t;

    state_t           state_q;
    logic             level_q;
    logic             ffwd_q;

    ptp_ts_t          time_q;
    ptp_ts_t          next_rise;
    ptp_ts_t          next_fall;
    logic [NSF_W-1:0] sum_q;
    logic [NSF_W-1:0] ovf_q;

    logic             in_rise;
    ptp_ts_t          step_ts;
    logic [NSF_W-1:0] add_sum;
    logic [NSF_W-1:0] add_ovf;
    logic [NSF_W-1:0] nsf_pick;
    logic [SEC_W-1:0] sec_sum;
    ptp_ts_t          upd_ts;
    logic             rise_hit;
    logic             fall_hit;

    // drops fractional ns everywhere when they are not scheduled
    function automatic ptp_ts_t fns_mask(input ptp_ts_t t);
        ptp_ts_t r;
        r = t;
        if (!FNS_ENABLE) begin
            r.fns = '0;
        end
        return r;
    endfunction

    // rise updates add the period, fall updates add the width to next rise
    assign in_rise = (state_q == S_RISE_1) || (state_q == S_RISE_2);
    assign step_ts = fns_mask(in_rise ? cfg.period : cfg.width);

    // stage 1: plain sum and the minus one second lookahead side by side
    assign add_sum = {next_rise.ns[NS_SUM_W-1:0], next_rise.fns} +
                     {step_ts.ns[NS_SUM_W-1:0], step_ts.fns};
    assign add_ovf = add_sum - NSF_ONE_SEC;

    // stage 2: the lookahead borrow picks the result and the seconds carry
    assign nsf_pick = ovf_q[NSF_W-1] ? sum_q : ovf_q;
    assign sec_sum  = next_rise.sec + step_ts.sec + SEC_W'(!ovf_q[NSF_W-1]);
    assign upd_ts   = {sec_sum, 1'b0, nsf_pick};

    assign rise_hit = time_q > next_rise;
    assign fall_hit = time_q > next_fall;

    always_ff @(posedge clk) begin
        time_q <= fns_mask(ts_96);
        sum_q  <= add_sum;
        ovf_q  <= add_ovf;
        if (state_q == S_IDLE) begin
            next_rise <= fns_mask(cfg.start);
        end
        if (state_q == S_RISE_2) begin
            next_rise <= upd_ts;
        end
        if (state_q == S_FALL_2) begin
            next_fall <= upd_ts;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q           <= S_IDLE;
            level_q           <= 1'b0;
            ffwd_q            <= 1'b0;
            edge_bus.rise_evt <= 1'b0;
            edge_bus.fall_evt <= 1'b0;
            edge_bus.resync   <= 1'b0;
            edge_bus.step_evt <= 1'b0;
        end else begin
            edge_bus.rise_evt <= 1'b0;
            edge_bus.fall_evt <= 1'b0;
            edge_bus.resync   <= 1'b0;
            edge_bus.step_evt <= 1'b0;
            if (cfg.reload || ts_step) begin
                // new schedule or time jump, start over from the start time
                state_q           <= S_IDLE;
                level_q           <= 1'b0;
                edge_bus.resync   <= 1'b1;
                edge_bus.step_evt <= ts_step;
            end else begin
                case (state_q)
                    S_IDLE: begin
                        level_q <= 1'b0;
                        ffwd_q  <= 1'b1;
                        state_q <= S_WAIT_EDGE;
                    end
                    S_RISE_1: state_q <= S_RISE_2;
                    S_RISE_2: state_q <= S_WAIT_EDGE;
                    S_FALL_1: state_q <= S_FALL_2;
                    S_FALL_2: state_q <= S_WAIT_EDGE;
                    S_WAIT_EDGE: begin
                        if (!level_q && rise_hit) begin
                            if (ffwd_q) begin
                                // rise already in the past, step on quietly
                                state_q <= S_RISE_1;
                            end else begin
                                level_q           <= 1'b1;
                                edge_bus.rise_evt <= 1'b1;
                                state_q           <= S_FALL_1;
                            end
                        end else if (level_q && fall_hit) begin
                            level_q           <= 1'b0;
                            edge_bus.fall_evt <= 1'b1;
                            state_q           <= S_RISE_1;
                        end else begin
                            // caught up with the time, real edges from here on
                            ffwd_q <= 1'b0;
                        end
                    end
                    default: state_q <= S_IDLE;
                endcase
            end
        end
    end

    a_evt_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(edge_bus.rise_evt && edge_bus.fall_evt)
    );

    // the fall update takes two cycles plus a compare after each rise
    a_evt_gap: assert property (
        @(posedge clk) disable iff (rst)
        edge_bus.rise_evt |=> !edge_bus.fall_evt [*2]
    );

endmodule

/* ptp_pulse_result.sv */
//**************************************************************************
// pulse result: output level, locked and error status, pulse counter
//**************************************************************************
`timescale 1ns/100ps

module ptp_pulse_result (
    input  logic        clk,
    input  logic        rst,
    ptp_cfg_if.status   cfg,
    ptp_edge_if.rcv     edge_bus,
    output logic        locked,
    output logic        error,
    output logic        output_pulse,
    output logic [15:0] pulse_count
);

    always_ff @(posedge clk) begin
        if (rst) begin
            locked       <= 1'b0;
            error        <= 1'b0;
            output_pulse <= 1'b0;
            pulse_count  <= 16'd0;
        end else if (edge_bus.resync) begin
            // a time step leaves error set until the next real rise
            output_pulse <= 1'b0;
            locked       <= 1'b0;
            error        <= edge_bus.step_evt;
        end else if (edge_bus.rise_evt) begin
            output_pulse <= cfg.enable;
            locked       <= 1'b1;
            error        <= 1'b0;
            if (cfg.enable) begin
                pulse_count <= pulse_count + 16'd1;
            end
        end else if (edge_bus.fall_evt) begin
            output_pulse <= 1'b0;
        end
    end

endmodule

/* ptp_perout_sys.sv */
//**************************************************************************
// PTP periodic output subsystem: time-of-day clock, config decode,
// edge scheduler and pulse result
//**************************************************************************
`timescale 1ns/100ps

module ptp_perout_sys
    import ptp_pkg::*;
#(
    parameter int unsigned NS_INC     = 4,
    parameter int unsigned FNS_INC    = 0,
    parameter bit          FNS_ENABLE = 1'b1,
    parameter ptp_ts_t     DEF_START  = PTP_DEF_START,
    parameter ptp_ts_t     DEF_PERIOD = PTP_DEF_PERIOD,
    parameter ptp_ts_t     DEF_WIDTH  = PTP_DEF_WIDTH
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_wr,
    input  logic [1:0]  cfg_addr,
    input  ptp_ts_t     cfg_data,
    input  logic        ts_set,
    input  ptp_ts_t     ts_set_value,
    output ptp_ts_t     ts_96,
    output logic        locked,
    output logic        error,
    output logic        output_pulse,
    output logic [15:0] pulse_count
);

    logic ts_step;

    ptp_cfg_if  cfg_bus ();
    ptp_edge_if edge_bus ();

    ptp_tod_clock #(
        .NS_INC  (NS_INC),
        .FNS_INC (FNS_INC)
    ) tod_clock_i (
        .clk          (clk),
        .rst          (rst),
        .ts_set       (ts_set),
        .ts_set_value (ts_set_value),
        .ts_96        (ts_96),
        .ts_step      (ts_step)
    );

    ptp_cfg_decode #(
        .DEF_START  (DEF_START),
        .DEF_PERIOD (DEF_PERIOD),
        .DEF_WIDTH  (DEF_WIDTH)
    ) cfg_decode_i (
        .clk      (clk),
        .rst      (rst),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .cfg      (cfg_bus.drv)
    );

    ptp_edge_sched #(
        .FNS_ENABLE (FNS_ENABLE)
    ) edge_sched_i (
        .clk      (clk),
        .rst      (rst),
        .ts_96    (ts_96),
        .ts_step  (ts_step),
        .cfg      (cfg_bus.sched),
        .edge_bus (edge_bus.drv)
    );

    ptp_pulse_result pulse_result_i (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg_bus.status),
        .edge_bus     (edge_bus.rcv),
        .locked       (locked),
        .error        (error),
        .output_pulse (output_pulse),
        .pulse_count  (pulse_count)
    );

endmodule

/* ptp_perout_checker.sv */
//**************************************************************************
// periodic output checker: follows ts_96 across rollover, measures pulse
// period and high time in ns, aligns rises to start and compares status
//**************************************************************************
`timescale 1ns/100ps

module ptp_perout_checker
    import ptp_pkg::*;
#(
    parameter int unsigned NS_STEP    = 4,
    parameter int unsigned LAT_MAX_NS = 24
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ts_set,
    input  ptp_ts_t     ts_96,
    input  logic        output_pulse,
    input  logic        locked,
    input  logic        error,
    input  logic [15:0] pulse_count,
    input  ptp_ts_t     start_set,
    input  ptp_ts_t     period_set,
    input  ptp_ts_t     width_set,
    input  logic        enable_set,
    input  logic        exp_valid,
    input  logic        exp_locked,
    input  logic        exp_error,
    input  logic [15:0] exp_count,
    output int          err_count
);

    int              errors = 0;
    ptp_ts_t         prev_ts;
    ptp_ts_t         exp_ts;
    logic            ts_valid;
    logic            set_q;
    logic            pulse_q;
    logic            have_rise;
    longint unsigned now_ns;
    longint unsigned rise_ns;
    longint unsigned delta;

    assign err_count = errors;

    function automatic longint unsigned to_ns(input ptp_ts_t t);
        return 64'(t.sec) * 64'd1_000_000_000 + 64'(t.ns);
    endfunction

    function automatic longint unsigned abs_diff(input longint unsigned a,
                                                 input longint unsigned b);
        return (a > b) ? a - b : b - a;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            ts_valid  = 1'b0;
            set_q     = 1'b0;
            pulse_q   = 1'b0;
            have_rise = 1'b0;
        end else begin
            // time advances by one step per cycle unless it was just loaded
            if (ts_valid && !set_q) begin
                exp_ts = prev_ts;
                exp_ts.ns = prev_ts.ns + NS_STEP;
                if (exp_ts.ns >= 32'(NS_PER_SEC)) begin
                    exp_ts.ns  = exp_ts.ns - 32'(NS_PER_SEC);
                    exp_ts.sec = prev_ts.sec + 1;
                end
                if (ts_96 !== exp_ts) begin
                    $display("error ts_96: expected %h got %h", exp_ts, ts_96);
                    errors++;
                end
            end
            ts_valid = 1'b1;
            set_q    = ts_set;
            prev_ts  = ts_96;
            now_ns   = to_ns(ts_96);

            if (output_pulse && !pulse_q) begin
                if (!enable_set) begin
                    $display("output pulse rose while the output was disabled");
                    errors++;
                end
                if (now_ns <= to_ns(start_set)) begin
                    $display("output pulse rose before the start time");
                    errors++;
                end else begin
                    // rise lands shortly after start plus whole periods
                    delta = (now_ns - to_ns(start_set)) % to_ns(period_set);
                    if (delta == 0 || delta > LAT_MAX_NS) begin
                        $display("error rise phase: expected %h got %h",
                                 LAT_MAX_NS, delta);
                        errors++;
                    end
                end
                if (have_rise && abs_diff(now_ns - rise_ns, to_ns(period_set)) > NS_STEP) begin
                    $display("error output_pulse period: expected %h got %h",
                             to_ns(period_set), now_ns - rise_ns);
                    errors++;
                end
                rise_ns   = now_ns;
                have_rise = 1'b1;
            end

            // a drop together with locked is a restart, not a pulse end
            if (!output_pulse && pulse_q && locked) begin
                if (abs_diff(now_ns - rise_ns, to_ns(width_set)) > NS_STEP) begin
                    $display("error output_pulse width: expected %h got %h",
                             to_ns(width_set), now_ns - rise_ns);
                    errors++;
                end
            end
            if (!locked) begin
                have_rise = 1'b0;
            end
            pulse_q = output_pulse;

            if (exp_valid) begin
                if (locked !== exp_locked) begin
                    $display("error locked: expected %h got %h", exp_locked, locked);
                    errors++;
                end
                if (error !== exp_error) begin
                    $display("error error: expected %h got %h", exp_error, error);
                    errors++;
                end
                if (pulse_count !== exp_count) begin
                    $display("error pulse_count: expected %h got %h", exp_count, pulse_count);
                    errors++;
                end
            end
        end
    end

endmodule

/* tb_ptp_perout_sys.sv */
//**************************************************************************
// testbench for the PTP periodic output subsystem, driven by commands
// from a stimulus file, with a separate checker module
//**************************************************************************
`timescale 1ns/100ps

module tb_ptp_perout_sys
    import ptp_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        cfg_wr;
    logic [1:0]  cfg_addr;
    ptp_ts_t     cfg_data;
    logic        ts_set;
    ptp_ts_t     ts_set_value;
    ptp_ts_t     ts_96;
    logic        locked;
    logic        error;
    logic        output_pulse;
    logic [15:0] pulse_count;

    // settings as last written, for the checker
    ptp_ts_t     start_set;
    ptp_ts_t     period_set;
    ptp_ts_t     width_set;
    logic        enable_set;

    logic        exp_valid;
    logic        exp_locked;
    logic        exp_error;
    logic [15:0] exp_count;
    int          check_errors;
    int          timeouts;
    int          setup_errors;

    ptp_perout_sys ptp_perout_sys_i (
        .clk          (clk),
        .rst          (rst),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .ts_set       (ts_set),
        .ts_set_value (ts_set_value),
        .ts_96        (ts_96),
        .locked       (locked),
        .error        (error),
        .output_pulse (output_pulse),
        .pulse_count  (pulse_count)
    );

    ptp_perout_checker checker_i (
        .clk          (clk),
        .rst          (rst),
        .ts_set       (ts_set),
        .ts_96        (ts_96),
        .output_pulse (output_pulse),
        .locked       (locked),
        .error        (error),
        .pulse_count  (pulse_count),
        .start_set    (start_set),
        .period_set   (period_set),
        .width_set    (width_set),
        .enable_set   (enable_set),
        .exp_valid    (exp_valid),
        .exp_locked   (exp_locked),
        .exp_error    (exp_error),
        .exp_count    (exp_count),
        .err_count    (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_cfg(input logic [1:0] addr, input ptp_ts_t data);
        next_cycle();
        cfg_wr   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        case (addr)
            CFG_ADDR_START:  start_set  = data;
            CFG_ADDR_PERIOD: period_set = data;
            CFG_ADDR_WIDTH:  width_set  = data;
            default:         enable_set = data[0];
        endcase
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic load_time(input ptp_ts_t value);
        next_cycle();
        ts_set       = 1'b1;
        ts_set_value = value;
        next_cycle();
        ts_set = 1'b0;
    endtask

    task automatic wait_rises(input int count, input int limit);
        int   seen;
        int   cycles;
        logic prev;
        seen   = 0;
        cycles = 0;
        prev   = output_pulse;
        while (seen < count && cycles < limit) begin
            next_cycle();
            if (output_pulse && !prev) begin
                seen++;
            end
            prev = output_pulse;
            cycles++;
        end
        if (seen < count) begin
            $display("timeout: saw %0d of %0d output pulses in %0d cycles", seen, count, limit);
            timeouts++;
        end
    endtask

    task automatic wait_locked(input int limit);
        int cycles;
        cycles = 0;
        while (!locked && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (!locked) begin
            $display("timeout: locked did not come back within %0d cycles", limit);
            timeouts++;
        end
    endtask

    task automatic expect_status(input int l, input int e, input int c);
        next_cycle();
        exp_valid  = 1'b1;
        exp_locked = l[0];
        exp_error  = e[0];
        exp_count  = c[15:0];
        next_cycle();
        exp_valid = 1'b0;
    endtask

    initial begin
        int          fd;
        int          c;
        int          code;
        int          n1;
        int          n2;
        int          n3;
        logic [3:0]  addr_rd;
        logic [95:0] data_rd;
        bit          done;
        rst          = 1'b1;
        cfg_wr       = 1'b0;
        cfg_addr     = 2'd0;
        cfg_data     = '0;
        ts_set       = 1'b0;
        ts_set_value = '0;
        start_set    = PTP_DEF_START;
        period_set   = PTP_DEF_PERIOD;
        width_set    = PTP_DEF_WIDTH;
        enable_set   = 1'b0;
        exp_valid    = 1'b0;
        exp_locked   = 1'b0;
        exp_error    = 1'b0;
        exp_count    = 16'd0;
        timeouts     = 0;
        setup_errors = 0;
        done         = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("perout_stimulus.dat", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            setup_errors++;
            done = 1'b1;
        end
        while (!done && timeouts == 0) begin
            c = $fgetc(fd);
            code = 0;
            if (c == -1) begin
                done = 1'b1;
            end else if (c == "#") begin
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (c == "W") begin
                code = $fscanf(fd, "%h %h", addr_rd, data_rd) - 2;
                write_cfg(addr_rd[1:0], data_rd);
            end else if (c == "L") begin
                code = $fscanf(fd, "%h", data_rd) - 1;
                load_time(data_rd);
            end else if (c == "N") begin
                code = $fscanf(fd, "%d", n1) - 1;
                repeat (n1) next_cycle();
            end else if (c == "R") begin
                code = $fscanf(fd, "%d %d", n1, n2) - 2;
                wait_rises(n1, n2);
            end else if (c == "K") begin
                code = $fscanf(fd, "%d", n1) - 1;
                wait_locked(n1);
            end else if (c == "E") begin
                code = $fscanf(fd, "%d %d %d", n1, n2, n3) - 3;
                expect_status(n1, n2, n3);
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                $display("unknown command character %0d in the stimulus file", c);
                setup_errors++;
                done = 1'b1;
            end
            if (code != 0) begin
                $display("a stimulus line has missing fields");
                setup_errors++;
                done = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (2) next_cycle();

        $display("errors: %0d check, %0d timeout, %0d setup", check_errors, timeouts,
                 setup_errors);
        if (check_errors == 0 && timeouts == 0 && setup_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* ptp_perout_sys.f */
ptp_pkg.sv
ptp_cfg_if.sv
ptp_edge_if.sv
ptp_tod_clock.sv
ptp_cfg_decode.sv
ptp_edge_sched.sv
ptp_pulse_result.sv
ptp_perout_sys.sv
ptp_perout_checker.sv
tb_ptp_perout_sys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ptp_perout_sys
FILELIST  ?= ptp_perout_sys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* perout_stimulus.dat */
# W addr data96 | L time96 | N cycles | R rises timeout | K timeout
# E locked error pulse_count   (data and time in hex: sec12 ns8 fns4)
E 0 0 0
L 00000000000A3B9AC9F80000
N 8
E 0 1 0
W 1 000000000000000000C80000
W 2 0000000000000000003C0000
W 3 000000000000000000000001
W 0 00000000000B000007D00000
R 1 1000
R 8 600
E 1 0 9
W 0 00000000000B000000000000
N 3
E 0 0 9
R 1 1000
E 1 0 10
W 1 000000000000000001400000
N 3
E 0 0 10
R 1 1000
R 4 500
E 1 0 15
W 0 00000000001400000FA00000
N 3
E 0 0 15
L 00000000001400000BB80000
N 3
E 0 1 15
R 1 600
E 1 0 16
W 3 000000000000000000000000
W 0 000000000014000000000000
N 3
E 0 0 16
K 400
E 1 0 16
N 400
E 1 0 16
